// File: mandel_patterns.hex
// Columns: kind (1 digit), expected count (4), x or c_re (8), y or c_im (8), tag or limit (4).
// Kinds: 1 parameters, 2 pixel job, 4 busy must be high, 5 drain batch, F end.
1000000000000000000000010  // c = 0, limit 16
2001000000000000000000001  // tag 0001, origin stays inside
2001000001000000000000006  // tag 0006, z = 1 is a fixed point
2000600001000000010000005  // tag 0005, 1+i escapes on pass 6
2000500002000000000000003  // tag 0003, z = 2 escapes on pass 5
4000000000000000000000000  // all four engines loaded
2000400004000000000000004  // tag 0004, z = 4 escapes on pass 4
20001003E8000000000000002  // tag 0002, z = 1000 overflows at once
5000000000000000000000000
10000FFFFF000000000000008  // c = -1, limit 8
2000800000000000000000011  // tag 0011, origin cycles 0, -1
2000800001000000000000013  // tag 0013, z = 1 joins the cycle
2000800000800000000000014  // tag 0014, z = 0.5 stays bounded
2000600000000000010000015  // tag 0015, z = i escapes on pass 6
4000000000000000000000000
2000500002000000000000012  // tag 0012, z = 2 escapes on pass 5
20001FFC18000000000000016  // tag 0016, z = -1000 overflows at once
5000000000000000000000000
F000000000000000000000000

// File: project.f
+incdir+.
mandel_pkg.sv
mandel_if.sv
complex_square.sv
mandel_pixel_engine.sv
job_dispatcher.sv
result_collector.sv
mandel_array_top.sv
tb_mandel_array.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the fractal engine array testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module tb_mandel_array -o tb_mandel_array; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_mandel_array > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation ended with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: tb_mandel_array.sv
`timescale 1ns/100ps

module tb_mandel_array;

    localparam int DEPTH   = 64;     // Pattern entries read.
    localparam int ENTRY_W = 100;    // Kind, expected count, command word.

    logic                                     clk;
    logic                                     reset;
    logic                                     cmd_valid;
    logic                                     cmd_is_param;
    logic [$bits(mandel_pkg::cmd_word_u)-1:0] cmd_word;
    logic                                     busy;
    logic                                     result_valid;
    mandel_pkg::cnt_t                         result_count;
    mandel_pkg::tag_t                         result_tag;

    logic [ENTRY_W-1:0] patterns [DEPTH];
    mandel_pkg::cnt_t   exp_count [mandel_pkg::tag_t];    // Open jobs by tag.
    mandel_pkg::tag_t   sent_tags [$];
    mandel_pkg::tag_t   got_tags [$];
    int                 num_patterns;
    int                 error_count = 0;
    int                 limit_cycles = 0;

    mandel_array_top UUT (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_is_param (cmd_is_param),
        .cmd_word     (cmd_word),
        .busy         (busy),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_tag   (result_tag)
    );

    always #50 clk = ~clk;

    // **********************************************************************
    // Error handling and compare tasks
    // **********************************************************************
    task automatic abort_run(input string what);
        error_count++;
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input mandel_pkg::cnt_t expected,
                               input mandel_pkg::cnt_t actual);
        if (actual !== expected)
            abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic check_tag(input string name, input mandel_pkg::tag_t expected,
                             input mandel_pkg::tag_t actual);
        if (actual !== expected)
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    endtask

    // Called on a falling edge, returns on the falling edge after the strobe.
    task automatic send_cmd(input logic is_param, input logic [79:0] word);
        while (busy)
            @(negedge clk);
        cmd_valid    = 1'b1;
        cmd_is_param = is_param;
        cmd_word     = word;
        @(negedge clk);
        cmd_valid    = 1'b0;
    endtask

    // Wait for the whole batch, then compare the tag sets.
    task automatic drain_batch;
        while (got_tags.size() < sent_tags.size())
            @(negedge clk);
        sent_tags.sort();
        got_tags.sort();
        foreach (sent_tags[i])
            check_tag($sformatf("returned tag %0d of batch", i), sent_tags[i], got_tags[i]);
        sent_tags.delete();
        got_tags.delete();
    endtask

    // Score each result as the collector hands it out.
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (exp_count.exists(result_tag)) begin
                check_count($sformatf("count of tag %h", result_tag),
                            exp_count[result_tag], result_count);
                exp_count.delete(result_tag);
            end
            got_tags.push_back(result_tag);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles with results still missing",
                            limit_cycles));
    end

    // **********************************************************************
    // Pattern sequencer
    // **********************************************************************
    initial begin
        logic [ENTRY_W-1:0] entry;
        int                 max_limit;
        clk          = 1'b0;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_is_param = 1'b0;
        cmd_word     = '0;
        $readmemh("mandel_patterns.hex", patterns);
        num_patterns = 0;
        max_limit    = 1;
        while (num_patterns < DEPTH && patterns[num_patterns][99:96] !== 4'hF) begin
            entry = patterns[num_patterns];
            if (entry[99:96] == 4'h1 && int'(entry[15:0]) > max_limit)
                max_limit = int'(entry[15:0]);
            num_patterns++;
        end
        limit_cycles = num_patterns * max_limit * 4 + 200;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (result_valid !== 1'b0 || busy !== 1'b0)
                abort_run("result_valid or busy went high after reset with no command sent");
        end

        for (int i = 0; i < num_patterns; i++) begin
            entry = patterns[i];
            case (entry[99:96])
                4'h1: send_cmd(1'b1, entry[79:0]);    // New c and limit.
                4'h2: begin
                    exp_count[entry[15:0]] = entry[95:80];
                    sent_tags.push_back(entry[15:0]);
                    send_cmd(1'b0, entry[79:0]);
                end
                4'h4: begin
                    if (busy !== 1'b1)
                        abort_run("busy stayed low with every engine loaded");
                end
                4'h5: drain_batch();
                default: abort_run($sformatf("Unknown pattern kind at entry %0d", i));
            endcase
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("Checks failed during the run");
        end
    end

endmodule

// File: mandel_array_top.sv
`timescale 1ns/100ps
`include "mandel_params.svh"

module mandel_array_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cmd_valid,
    input  logic                                    cmd_is_param,
    input  logic [$bits(mandel_pkg::cmd_word_u)-1:0] cmd_word,
    output logic                                    busy,
    output logic                                    result_valid,
    output mandel_pkg::cnt_t                        result_count,
    output mandel_pkg::tag_t                        result_tag
);

    mandel_pkg::cmd_word_u cmd_u;
    mandel_pkg::fix_t      c_re;
    mandel_pkg::fix_t      c_im;
    mandel_pkg::cnt_t      max_iters;

    job_if    jobs [`MB_ENGINES] ();
    result_if results [`MB_ENGINES] ();

    assign cmd_u = cmd_word;

    job_dispatcher u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_is_param (cmd_is_param),
        .cmd_word     (cmd_u),
        .jobs         (jobs),
        .mon          (results),
        .c_re         (c_re),
        .c_im         (c_im),
        .max_iters    (max_iters),
        .all_busy     (busy)
    );

    // **********************************************************************
    // Engine array
    // **********************************************************************
    for (genvar i = 0; i < `MB_ENGINES; i++) begin : g_engine
        mandel_pixel_engine u_engine (
            .clk       (clk),
            .reset     (reset),
            .job       (jobs[i]),
            .res       (results[i]),
            .c_re      (c_re),
            .c_im      (c_im),
            .max_iters (max_iters)
        );
    end

    result_collector u_collect (
        .clk          (clk),
        .reset        (reset),
        .res          (results),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_tag   (result_tag)
    );

endmodule

// File: result_collector.sv
`timescale 1ns/100ps
`include "mandel_params.svh"

module result_collector (
    input  logic             clk,
    input  logic             reset,
    result_if.collector      res [`MB_ENGINES],
    output logic             result_valid,
    output mandel_pkg::cnt_t result_count,
    output mandel_pkg::tag_t result_tag
);

    localparam int N  = `MB_ENGINES;
    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]     done_v;
    logic [N-1:0]     ack_v;
    mandel_pkg::cnt_t cnt_v [N];
    mandel_pkg::tag_t tag_v [N];
    logic [PW-1:0]    ptr;
    logic [PW-1:0]    sel;
    logic             found;

    for (genvar i = 0; i < N; i++) begin : g_eng
        assign done_v[i]  = res[i].done;
        assign cnt_v[i]   = res[i].count;
        assign tag_v[i]   = res[i].tag;
        assign res[i].ack = ack_v[i];
    end

    // First done engine at or after the pointer.
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = ptr;
        ack_v = '0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr) + k) % N;
            if (!found && done_v[idx]) begin
                found = 1'b1;
                sel   = PW'(idx);
            end
        end
        if (found)
            ack_v[sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= found;
            if (found)
                ptr <= (sel == PW'(N - 1)) ? '0 : sel + 1'b1;   // Past the winner.
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            result_count <= cnt_v[sel];
            result_tag   <= tag_v[sel];
        end
    end

endmodule

// File: job_dispatcher.sv
`timescale 1ns/100ps
`include "mandel_params.svh"

module job_dispatcher (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  logic                  cmd_is_param,
    input  mandel_pkg::cmd_word_u cmd_word,
    job_if.dispatcher             jobs [`MB_ENGINES],
    result_if.monitor             mon [`MB_ENGINES],
    output mandel_pkg::fix_t      c_re,
    output mandel_pkg::fix_t      c_im,
    output mandel_pkg::cnt_t      max_iters,
    output logic                  all_busy
);

    localparam int N  = `MB_ENGINES;
    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]     idle;
    logic [N-1:0]     start_r;
    logic [PW-1:0]    pick;
    logic             any_idle;
    mandel_pkg::fix_t x_r;
    mandel_pkg::fix_t y_r;
    mandel_pkg::tag_t tag_r;

    // An engine with a start in flight is not idle yet.
    for (genvar i = 0; i < N; i++) begin : g_eng
        assign idle[i]        = !mon[i].busy && !start_r[i];
        assign jobs[i].start  = start_r[i];
        assign jobs[i].x_init = x_r;
        assign jobs[i].y_init = y_r;
        assign jobs[i].tag    = tag_r;
    end

    // Lowest index idle engine wins.
    always_comb begin
        any_idle = 1'b0;
        pick     = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (idle[i]) begin
                any_idle = 1'b1;
                pick     = PW'(i);
            end
        end
    end

    assign all_busy = !any_idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_r   <= '0;
            c_re      <= '0;
            c_im      <= '0;
            max_iters <= '0;
        end else begin
            start_r <= '0;
            if (cmd_valid && cmd_is_param) begin
                c_re      <= cmd_word.param.c_re;
                c_im      <= cmd_word.param.c_im;
                max_iters <= cmd_word.param.max_iters;
            end else if (cmd_valid && any_idle) begin
                start_r[pick] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && !cmd_is_param) begin
            x_r   <= cmd_word.pixel.x_init;
            y_r   <= cmd_word.pixel.y_init;
            tag_r <= cmd_word.pixel.tag;
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_is_param |-> !all_busy);

endmodule

// File: mandel_pixel_engine.sv
`timescale 1ns/100ps
`include "mandel_params.svh"

module mandel_pixel_engine (
    input  logic             clk,
    input  logic             reset,
    job_if.engine            job,
    result_if.engine         res,
    input  mandel_pkg::fix_t c_re,
    input  mandel_pkg::fix_t c_im,
    input  mandel_pkg::cnt_t max_iters
);

    localparam int W     = `MB_WIDTH;
    localparam int P     = `MB_POINT;
    localparam int SUM_W = 2 * W - P + 1;

    typedef enum logic {IDLE, RUN} state_t;

    state_t                  state;
    logic                    busy_r;
    logic                    done_r;
    logic                    feed;
    logic                    sq_valid;
    logic                    sum_valid;
    mandel_pkg::cnt_t        count;
    mandel_pkg::cnt_t        count_next;
    mandel_pkg::tag_t        tag_r;
    mandel_pkg::fix_t        z_re;
    mandel_pkg::fix_t        z_im;
    logic signed [2*W:0]     sq_re;
    logic signed [2*W:0]     sq_im;
    logic signed [SUM_W-1:0] c_re_ext;
    logic signed [SUM_W-1:0] c_im_ext;
    logic signed [SUM_W-1:0] sum_re;
    logic signed [SUM_W-1:0] sum_im;
    logic                    ovf;

    complex_square u_square (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (feed),
        .z_re      (z_re),
        .z_im      (z_im),
        .out_valid (sq_valid),
        .sq_re     (sq_re),
        .sq_im     (sq_im)
    );

    assign c_re_ext = c_re;    // Sign extended.
    assign c_im_ext = c_im;

    // **********************************************************************
    // Rescale and add c
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (sq_valid) begin
            sum_re <= $signed(sq_re[2*W:P]) + c_re_ext;
            sum_im <= $signed(sq_im[2*W:P]) + c_im_ext;
        end
    end

    // Sum fits the word when the top bits are all sign.
    assign ovf = !((&sum_re[SUM_W-1:W-1]) || !(|sum_re[SUM_W-1:W-1])) ||
                 !((&sum_im[SUM_W-1:W-1]) || !(|sum_im[SUM_W-1:W-1]));

    assign count_next = count + 1'b1;

    // **********************************************************************
    // Iteration control
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            busy_r    <= 1'b0;
            done_r    <= 1'b0;
            feed      <= 1'b0;
            sum_valid <= 1'b0;
            count     <= '0;
        end else begin
            feed      <= 1'b0;
            sum_valid <= sq_valid;
            if (done_r && res.ack) begin
                done_r <= 1'b0;     // Result drained.
                busy_r <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (job.start) begin
                        state  <= RUN;
                        busy_r <= 1'b1;
                        count  <= '0;
                        feed   <= 1'b1;
                    end
                end
                RUN: begin
                    if (sum_valid) begin
                        count <= count_next;
                        if (ovf || count_next >= max_iters) begin
                            state  <= IDLE;
                            done_r <= 1'b1;
                        end else begin
                            feed <= 1'b1;   // Next iteration.
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Start point, then the cast result of each pass.
    always_ff @(posedge clk) begin
        if (state == IDLE && job.start) begin
            z_re  <= job.x_init;
            z_im  <= job.y_init;
            tag_r <= job.tag;
        end else if (state == RUN && sum_valid) begin
            z_re <= sum_re[W-1:0];
            z_im <= sum_im[W-1:0];
        end
    end

    assign res.busy  = busy_r;
    assign res.done  = done_r;
    assign res.count = count;
    assign res.tag   = tag_r;

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        job.start |-> !busy_r);
    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        done_r |-> busy_r && state == IDLE);

endmodule

// File: complex_square.sv
`timescale 1ns/100ps
`include "mandel_params.svh"

module complex_square (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mandel_pkg::fix_t          z_re,
    input  mandel_pkg::fix_t          z_im,
    output logic                      out_valid,
    output logic signed [2*`MB_WIDTH:0] sq_re,
    output logic signed [2*`MB_WIDTH:0] sq_im
);

    localparam int PW = 2 * `MB_WIDTH;

    logic                 valid_s1;
    logic signed [PW-1:0] re_sq;
    logic signed [PW-1:0] im_sq;
    logic signed [PW-1:0] re_im;

    // **********************************************************************
    // Stage 1 products
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (in_valid) begin
            re_sq <= z_re * z_re;
            im_sq <= z_im * z_im;
            re_im <= z_re * z_im;
        end
    end

    // **********************************************************************
    // Stage 2 real and imaginary parts
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (valid_s1) begin
            sq_re <= (PW+1)'(re_sq) - (PW+1)'(im_sq);   // Re^2 - im^2.
            sq_im <= (PW+1)'(re_im) <<< 1;              // 2 re im.
        end
    end

    // Valid bit walks with the data.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
        end
    end

endmodule

// File: mandel_if.sv
`timescale 1ns/100ps

// Dispatcher to engine job hand-off.
interface job_if;
    logic             start;     // One-cycle pulse.
    mandel_pkg::fix_t x_init;
    mandel_pkg::fix_t y_init;
    mandel_pkg::tag_t tag;

    modport dispatcher (output start, x_init, y_init, tag);
    modport engine (input start, x_init, y_init, tag);
endinterface

// Engine status and result, drained by the collector.
interface result_if;
    logic             busy;
    logic             done;      // Held until ack.
    mandel_pkg::cnt_t count;
    mandel_pkg::tag_t tag;
    logic             ack;       // One-cycle pulse.

    modport engine (output busy, done, count, tag, input ack);
    modport collector (input done, count, tag, output ack);
    modport monitor (input busy);
endinterface

// File: mandel_pkg.sv
`include "mandel_params.svh"

package mandel_pkg;

    typedef logic signed [`MB_WIDTH-1:0] fix_t;    // Signed fixed point.
    typedef logic [`MB_TAG_W-1:0] tag_t;
    typedef logic [`MB_CNT_W-1:0] cnt_t;

    // Start point of one pixel job.
    typedef struct packed {
        fix_t x_init;
        fix_t y_init;
        tag_t tag;
    } pixel_cmd_t;

    // Shared constant and iteration limit.
    typedef struct packed {
        fix_t c_re;
        fix_t c_im;
        cnt_t max_iters;
    } param_cmd_t;

    // One host word, read as pixel or parameter command by cmd_is_param.
    typedef union packed {
        pixel_cmd_t pixel;
        param_cmd_t param;
    } cmd_word_u;

endpackage

// File: mandel_params.svh
`ifndef MANDEL_PARAMS_SVH
`define MANDEL_PARAMS_SVH

// **********************************************************************
// Fixed-point format
// **********************************************************************
`define MB_WIDTH 32     // Word width of z and c.
`define MB_POINT 12     // Fraction bits.

// **********************************************************************
// Array size and field widths
// **********************************************************************
`define MB_ENGINES 4    // Pixel engines in the array.
`define MB_TAG_W 16     // Pixel tag width.
`define MB_CNT_W 16     // Iteration count width.

`endif
